//--- soc_cfg.svh
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// bus slave address map
// all addresses are full 64-bit bus addresses

// data ram window
// starts at zero, one word per 4 bytes
`define RAM_BASE        64'h0000_0000_0000_0000
// depth in 32-bit words
`define RAM_WORDS       3072
// window size in bytes
`define RAM_BYTES       (4 * `RAM_WORDS)

// keyboard
// last ascii code, read only
`define KEY_ADDR        64'h0000_0000_1000_0000

// console
// write pushes low word out as one strobe
`define UART_ADDR       64'h0000_0000_1000_0008

// sd card control block
// sector number register
`define SDC_SECTOR_ADDR 64'h0000_0000_2000_0000
// write here to start a sector read
`define SDC_READ_ADDR   64'h0000_0000_2000_0008
// controller ready level, bit 0
`define SDC_READY_ADDR  64'h0000_0000_2000_0010
// full sector in buffer, bit 0
`define SDC_AVAIL_ADDR  64'h0000_0000_2000_0018

// sector buffer window
// one byte per address
`define SDC_BUF_BASE    64'h0000_0000_2000_1000
// bytes per sector
`define SECTOR_BYTES    512

`endif

//--- bus_pkg.sv
package bus_pkg;

    // bus address and data
    typedef logic [63:0] addr_t;
    typedef logic [63:0] dword_t;

    // ram side
    typedef logic [31:0] word_t;
    // 3072 words need 12 bits
    typedef logic [11:0] word_idx_t;
    // one bit per byte of a word
    typedef logic [3:0]  lane_mask_t;

    // load/store width code
    // stores reuse the low codes: sb=lb, sh=lh, sw=lw, sd=ld
    typedef enum logic [2:0] {
        ls_lb  = 3'b000,
        ls_lh  = 3'b001,
        ls_lw  = 3'b010,
        ls_ld  = 3'b011,
        ls_lbu = 3'b100,
        ls_lhu = 3'b101,
        ls_lwu = 3'b110
    } ls_type_t;

    // processor request
    typedef struct packed {
        addr_t    addr;
        dword_t   wdata;
        logic     rd_en;
        logic     wr_en;
        ls_type_t ls;
    } bus_req_t;

    // one ram access per cycle
    typedef struct packed {
        word_idx_t  idx;
        word_t      wdata;
        lane_mask_t lanes;
        logic       we;
    } ram_port_t;

    // access sequencer states
    typedef enum logic [2:0] {
        st_idle,
        st_rd_ram,
        st_rd_hi,
        st_rd_buf,
        st_wr_hi
    } bus_state_t;

endpackage

//--- periph_pkg.sv
package periph_pkg;

    // single data byte
    typedef logic [7:0] byte_t;

    // byte position inside a 512-byte sector
    typedef logic [8:0] sector_idx_t;

    // sd card sector number
    typedef logic [31:0] sector_addr_t;

    // interrupt number seen by the cpu
    typedef logic [3:0] irq_vec_t;

    // keyboard output
    // pressed is a level, held while the key is down
    typedef struct packed {
        byte_t ascii;
        logic  pressed;
    } key_event_t;

    // sd controller read stream
    // new byte on each rising byte_available
    typedef struct packed {
        logic  byte_available;
        byte_t dout;
    } sd_stream_t;

endpackage

//--- ram_bank.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module ram_bank
    import bus_pkg::*;
(
    input  logic      CLOCK_50,
    input  ram_port_t ram,
    output word_t     rdata
);
    // data ram, one 32-bit word per entry
    word_t mem [`RAM_WORDS];

    // write with byte lanes
    // lanes off keep their old byte
    always_ff @(posedge CLOCK_50) begin
        if (ram.we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (ram.lanes[lane]) begin
                    mem[ram.idx][8*lane +: 8] <= ram.wdata[8*lane +: 8];
                end
            end
        end
    end

    // registered read
    // word at idx shows up one edge later
    // read during write returns the old word
    always_ff @(posedge CLOCK_50) begin
        rdata <= mem[ram.idx];
    end

endmodule

//--- sector_fill_counter.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module sector_fill_counter
    import periph_pkg::*;
(
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  sd_stream_t  sd_stream,
    output logic        wr_en,
    output sector_idx_t wr_idx,
    output byte_t       wr_data,
    output logic        sector_avail
);
    logic        avail_d;
    logic        byte_edge;
    sector_idx_t count;

    // rising byte_available marks a new byte
    assign byte_edge = sd_stream.byte_available && !avail_d;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            avail_d      <= 1'b0;
            count        <= '0;
            wr_en        <= 1'b0;
            sector_avail <= 1'b0;
        end else begin
            avail_d <= sd_stream.byte_available;
            wr_en   <= byte_edge;
            if (byte_edge) begin
                // wraps at 512 by width
                count <= count + 9'd1;
                // first byte of the next sector
                if (count == '0) begin
                    sector_avail <= 1'b0;
                end
            end
            // last byte of the sector goes into the buffer now
            if (wr_en && wr_idx == sector_idx_t'(`SECTOR_BYTES - 1)) begin
                sector_avail <= 1'b1;
            end
        end
    end

    // byte and its slot, written one cycle behind the stream
    always_ff @(posedge CLOCK_50) begin
        if (byte_edge) begin
            wr_idx  <= count;
            wr_data <= sd_stream.dout;
        end
    end

    // each write follows a low then high byte_available
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        wr_en |-> $past(sd_stream.byte_available) && !$past(sd_stream.byte_available, 2));

endmodule

//--- sector_buffer.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module sector_buffer
    import periph_pkg::*;
(
    input  logic        CLOCK_50,
    input  logic        wr_en,
    input  sector_idx_t wr_idx,
    input  byte_t       wr_data,
    input  sector_idx_t rd_idx,
    output byte_t       rd_data
);
    // one sector of sd data
    byte_t mem [`SECTOR_BYTES];

    // fill side
    always_ff @(posedge CLOCK_50) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // bus side, registered
    always_ff @(posedge CLOCK_50) begin
        rd_data <= mem[rd_idx];
    end

endmodule

//--- key_irq_ctrl.sv
`timescale 1ns/1ps

module key_irq_ctrl
    import periph_pkg::*;
(
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  key_event_t key,
    input  logic       interrupt_ack,
    output irq_vec_t   interrupt_vector,
    output logic       irq_led
);
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            interrupt_vector <= '0;
            irq_led          <= 1'b0;
        end else begin
            // key down with a real character raises vector 1
            if (key.pressed && key.ascii != 8'd0) begin
                interrupt_vector <= 4'd1;
                irq_led          <= 1'b1;
            end
            // ack wins over a press in the same cycle
            if (interrupt_vector != '0 && interrupt_ack) begin
                interrupt_vector <= '0;
                irq_led          <= 1'b0;
            end
        end
    end

    // led mirrors a pending interrupt
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        irq_led == (interrupt_vector != '0));

endmodule

//--- bus_access_fsm.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module bus_access_fsm
    import bus_pkg::*, periph_pkg::*;
(
    input  logic         CLOCK_50,
    input  logic         KEY0,
    input  bus_req_t     bus_req,
    output dword_t       bus_rdata,
    output logic         bus_read_done,
    output logic         bus_write_done,
    output ram_port_t    ram,
    input  word_t        ram_rdata,
    output sector_idx_t  buf_idx,
    input  byte_t        buf_rdata,
    input  byte_t        key_ascii,
    input  logic         sd_ready,
    input  logic         sector_avail,
    output logic         uart_write,
    output word_t        uart_data,
    output sector_addr_t sd_sector,
    output logic         sd_rd_start
);
    bus_state_t state;
    addr_t      ram_off;
    addr_t      buf_off;
    word_idx_t  word_idx;
    logic [1:0] byte_off;
    logic       ram_sel;
    logic       buf_sel;
    logic       key_sel;
    logic       uart_sel;
    logic       sec_sel;
    logic       start_sel;
    logic       ready_sel;
    logic       avail_sel;
    logic       rd_pend;
    logic       wr_pend;

    // region decode, addr is held for the whole access
    assign ram_off   = bus_req.addr - `RAM_BASE;
    assign buf_off   = bus_req.addr - `SDC_BUF_BASE;
    assign ram_sel   = (bus_req.addr >= `RAM_BASE) && (bus_req.addr < `RAM_BASE + `RAM_BYTES);
    assign buf_sel   = (bus_req.addr >= `SDC_BUF_BASE) &&
                       (bus_req.addr < `SDC_BUF_BASE + `SECTOR_BYTES);
    assign key_sel   = (bus_req.addr == `KEY_ADDR);
    assign uart_sel  = (bus_req.addr == `UART_ADDR);
    assign sec_sel   = (bus_req.addr == `SDC_SECTOR_ADDR);
    assign start_sel = (bus_req.addr == `SDC_READ_ADDR);
    assign ready_sel = (bus_req.addr == `SDC_READY_ADDR);
    assign avail_sel = (bus_req.addr == `SDC_AVAIL_ADDR);
    assign word_idx  = ram_off[13:2];
    assign byte_off  = bus_req.addr[1:0];
    assign buf_idx   = buf_off[8:0];

    // idle with done low is the decode cycle right after the enable
    assign rd_pend = (state == st_idle) && !bus_read_done;
    assign wr_pend = (state == st_idle) && !bus_write_done;

    always_comb begin
        ram.idx   = word_idx;
        ram.wdata = bus_req.wdata[31:0];
        ram.lanes = 4'b1111;
        ram.we    = 1'b0;
        // second word of ld/sd
        // in st_rd_ram this prefetches the high word for ld
        if (state == st_rd_ram || state == st_wr_hi) begin
            ram.idx = word_idx + 12'd1;
        end
        if (wr_pend && ram_sel) begin
            ram.we = 1'b1;
            case (bus_req.ls)
                ls_lb: begin
                    // byte copied to every lane, mask picks one
                    ram.wdata = {4{bus_req.wdata[7:0]}};
                    ram.lanes = 4'b0001 << byte_off;
                end
                ls_lh: begin
                    ram.wdata = {2{bus_req.wdata[15:0]}};
                    ram.lanes = byte_off[1] ? 4'b1100 : 4'b0011;
                end
                default: ram.lanes = 4'b1111;
            endcase
        end
        if (state == st_wr_hi) begin
            ram.we    = 1'b1;
            ram.wdata = bus_req.wdata[63:32];
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state          <= st_idle;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            uart_write     <= 1'b0;
            sd_rd_start    <= 1'b0;
            sd_sector      <= '0;
        end else begin
            // strobes are single cycle
            uart_write  <= 1'b0;
            sd_rd_start <= 1'b0;
            if (bus_req.rd_en) begin
                bus_read_done <= 1'b0;
            end
            if (bus_req.wr_en) begin
                bus_write_done <= 1'b0;
            end
            case (state)
                st_idle: begin
                    if (rd_pend) begin
                        // ram and buffer wait for their registered read
                        if (ram_sel) begin
                            state <= st_rd_ram;
                        end else if (buf_sel) begin
                            state <= st_rd_buf;
                        end else begin
                            bus_read_done <= 1'b1;
                        end
                    end
                    if (wr_pend) begin
                        if (ram_sel && bus_req.ls == ls_ld) begin
                            state <= st_wr_hi;
                        end else begin
                            bus_write_done <= 1'b1;
                        end
                        uart_write  <= uart_sel;
                        sd_rd_start <= start_sel;
                        if (sec_sel) begin
                            sd_sector <= bus_req.wdata[31:0];
                        end
                    end
                end
                st_rd_ram: begin
                    if (bus_req.ls == ls_ld) begin
                        state <= st_rd_hi;
                    end else begin
                        state         <= st_idle;
                        bus_read_done <= 1'b1;
                    end
                end
                st_rd_hi, st_rd_buf: begin
                    state         <= st_idle;
                    bus_read_done <= 1'b1;
                end
                st_wr_hi: begin
                    state          <= st_idle;
                    bus_write_done <= 1'b1;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // read data and console word
    always_ff @(posedge CLOCK_50) begin
        if (rd_pend && !ram_sel && !buf_sel) begin
            // unmapped reads return zero
            bus_rdata <= '0;
            if (key_sel) begin
                bus_rdata <= {56'd0, key_ascii};
            end
            if (ready_sel) begin
                bus_rdata <= {63'd0, sd_ready};
            end
            if (avail_sel) begin
                bus_rdata <= {63'd0, sector_avail};
            end
        end
        if (state == st_rd_ram) begin
            if (bus_req.ls == ls_ld) begin
                bus_rdata[31:0] <= ram_rdata;
            end else begin
                // zero fill, no sign extension
                bus_rdata <= {32'd0, ram_rdata >> {byte_off, 3'b000}};
            end
        end
        if (state == st_rd_hi) begin
            bus_rdata[63:32] <= ram_rdata;
        end
        if (state == st_rd_buf) begin
            bus_rdata <= {56'd0, buf_rdata};
        end
        if (wr_pend && uart_sel) begin
            uart_data <= bus_req.wdata[31:0];
        end
    end

    // processor never asks for a read and a write at once
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(bus_req.rd_en && bus_req.wr_en));

    // a ram write always touches at least one lane
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        ram.we |-> (ram.lanes != 4'b0000));

endmodule

//--- soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top
    import bus_pkg::*, periph_pkg::*;
(
    input  logic         CLOCK_50,
    input  logic         KEY0,
    input  bus_req_t     bus_req,
    output dword_t       bus_rdata,
    output logic         bus_read_done,
    output logic         bus_write_done,
    input  key_event_t   key,
    input  logic         interrupt_ack,
    output irq_vec_t     interrupt_vector,
    output logic         irq_led,
    output logic         uart_write,
    output word_t        uart_data,
    output sector_addr_t sd_sector,
    output logic         sd_rd_start,
    input  logic         sd_ready,
    input  sd_stream_t   sd_stream
);
    // ram path
    ram_port_t   ram;
    word_t       ram_rdata;
    // sector buffer path
    sector_idx_t buf_idx;
    byte_t       buf_rdata;
    logic        fill_wr_en;
    sector_idx_t fill_wr_idx;
    byte_t       fill_wr_data;
    logic        sector_avail;

    bus_access_fsm bus_access_fsm_i (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .bus_req       (bus_req),
        .bus_rdata     (bus_rdata),
        .bus_read_done (bus_read_done),
        .bus_write_done(bus_write_done),
        .ram           (ram),
        .ram_rdata     (ram_rdata),
        .buf_idx       (buf_idx),
        .buf_rdata     (buf_rdata),
        .key_ascii     (key.ascii),
        .sd_ready      (sd_ready),
        .sector_avail  (sector_avail),
        .uart_write    (uart_write),
        .uart_data     (uart_data),
        .sd_sector     (sd_sector),
        .sd_rd_start   (sd_rd_start)
    );

    ram_bank ram_bank_i (
        .CLOCK_50(CLOCK_50),
        .ram     (ram),
        .rdata   (ram_rdata)
    );

    sector_fill_counter sector_fill_counter_i (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .sd_stream   (sd_stream),
        .wr_en       (fill_wr_en),
        .wr_idx      (fill_wr_idx),
        .wr_data     (fill_wr_data),
        .sector_avail(sector_avail)
    );

    sector_buffer sector_buffer_i (
        .CLOCK_50(CLOCK_50),
        .wr_en   (fill_wr_en),
        .wr_idx  (fill_wr_idx),
        .wr_data (fill_wr_data),
        .rd_idx  (buf_idx),
        .rd_data (buf_rdata)
    );

    key_irq_ctrl key_irq_ctrl_i (
        .CLOCK_50        (CLOCK_50),
        .KEY0            (KEY0),
        .key             (key),
        .interrupt_ack   (interrupt_ack),
        .interrupt_vector(interrupt_vector),
        .irq_led         (irq_led)
    );

endmodule

//--- tb_soc_bus.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module tb_soc_bus
    import bus_pkg::*, periph_pkg::*;
;
    // test sizes
    localparam int N_WORDS     = 16;
    localparam int N_DOUBLES   = 8;
    localparam int N_BUF_READS = 32;
    localparam int STREAM_LEN  = `SECTOR_BYTES;
    // stores and loads per test, plus key, strobe and flag accesses
    localparam int ACCESSES    = 8 * N_WORDS + 6 * N_DOUBLES + 1 + 3 + 4 + N_BUF_READS;
    localparam int WATCHDOG_CYCLES = ACCESSES * 10 + STREAM_LEN * 4;

    logic         CLOCK_50;
    logic         KEY0;
    bus_req_t     bus_req;
    dword_t       bus_rdata;
    logic         bus_read_done;
    logic         bus_write_done;
    key_event_t   key;
    logic         interrupt_ack;
    irq_vec_t     interrupt_vector;
    logic         irq_led;
    logic         uart_write;
    word_t        uart_data;
    sector_addr_t sd_sector;
    logic         sd_rd_start;
    logic         sd_ready;
    sd_stream_t   sd_stream;

    // expected values held for the checks
    dword_t       exp_rdata;
    word_t        exp_uart;
    sector_addr_t exp_sector;
    // reference copies of ram and sector buffer
    word_t        ref_mem [`RAM_WORDS];
    byte_t        sector_ref [`SECTOR_BYTES];
    int           value_errors;
    int           other_errors;
    int           rd_wait;
    int           wr_wait;
    int           uart_pulses;
    int           start_pulses;

    soc_bus_top soc_bus_top_i (
        .CLOCK_50        (CLOCK_50),
        .KEY0            (KEY0),
        .bus_req         (bus_req),
        .bus_rdata       (bus_rdata),
        .bus_read_done   (bus_read_done),
        .bus_write_done  (bus_write_done),
        .key             (key),
        .interrupt_ack   (interrupt_ack),
        .interrupt_vector(interrupt_vector),
        .irq_led         (irq_led),
        .uart_write      (uart_write),
        .uart_data       (uart_data),
        .sd_sector       (sd_sector),
        .sd_rd_start     (sd_rd_start),
        .sd_ready        (sd_ready),
        .sd_stream       (sd_stream)
    );

    // 40 ns clock
    always #20 CLOCK_50 = ~CLOCK_50;

    // cycles spent waiting on each done, plus strobe counts
    always @(posedge CLOCK_50) begin
        rd_wait <= bus_read_done ? 0 : rd_wait + 1;
        wr_wait <= bus_write_done ? 0 : wr_wait + 1;
        if (KEY0 && uart_write) begin
            uart_pulses <= uart_pulses + 1;
        end
        if (KEY0 && sd_rd_start) begin
            start_pulses <= start_pulses + 1;
        end
    end

    // read data at the rise of done
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $rose(bus_read_done) |-> bus_rdata == exp_rdata)
    else begin
        value_errors++;
        $display("Fail %0t bus_rdata expected %h actual %h",
                 $time, exp_rdata, $sampled(bus_rdata));
    end

    // sector register after every write
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $rose(bus_write_done) |-> sd_sector == exp_sector)
    else begin
        value_errors++;
        $display("Fail %0t sd_sector expected %h actual %h",
                 $time, exp_sector, $sampled(sd_sector));
    end

    // console word travels with its strobe
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        uart_write |-> uart_data == exp_uart)
    else begin
        value_errors++;
        $display("Fail %0t uart_data expected %h actual %h",
                 $time, exp_uart, $sampled(uart_data));
    end

    // strobes last one cycle
    assert property (@(posedge CLOCK_50) disable iff (!KEY0) uart_write |=> !uart_write)
    else begin
        other_errors++;
        $display("uart_write stayed high for more than one cycle at %0t", $time);
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0) sd_rd_start |=> !sd_rd_start)
    else begin
        other_errors++;
        $display("sd_rd_start stayed high for more than one cycle at %0t", $time);
    end

    // every access ends within 4 cycles
    assert property (@(posedge CLOCK_50) disable iff (!KEY0) rd_wait <= 4 && wr_wait <= 4)
    else begin
        other_errors++;
        $display("bus access took longer than 4 cycles at %0t", $time);
    end

    // press with a character, no ack pending
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (key.pressed && key.ascii != 8'd0 && !(interrupt_ack && interrupt_vector != '0))
        |=> interrupt_vector == 4'd1)
    else begin
        value_errors++;
        $display("Fail %0t interrupt_vector expected %h actual %h",
                 $time, 4'd1, $sampled(interrupt_vector));
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (key.pressed && key.ascii != 8'd0 && !(interrupt_ack && interrupt_vector != '0))
        |=> irq_led)
    else begin
        value_errors++;
        $display("Fail %0t irq_led expected %b actual %b", $time, 1'b1, $sampled(irq_led));
    end

    // ack clears a pending vector
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (interrupt_ack && interrupt_vector != '0) |=> interrupt_vector == '0)
    else begin
        value_errors++;
        $display("Fail %0t interrupt_vector expected %h actual %h",
                 $time, 4'd0, $sampled(interrupt_vector));
    end

    // idle vector stays low without a real key, ascii zero included
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (interrupt_vector == '0 && !(key.pressed && key.ascii != 8'd0))
        |=> interrupt_vector == '0)
    else begin
        value_errors++;
        $display("Fail %0t interrupt_vector expected %h actual %h",
                 $time, 4'd0, $sampled(interrupt_vector));
    end

    // expected load by the shift rule
    function automatic dword_t load_ref(input addr_t addr, input ls_type_t ls);
        int         idx;
        logic [1:0] off;
        idx = int'((addr - `RAM_BASE) >> 2);
        off = addr[1:0];
        if (ls == ls_ld) begin
            return {ref_mem[idx + 1], ref_mem[idx]};
        end
        return {32'd0, ref_mem[idx] >> (8 * off)};
    endfunction

    function automatic void store_ref(input addr_t addr, input ls_type_t ls,
                                      input dword_t data);
        int         idx;
        logic [1:0] off;
        idx = int'((addr - `RAM_BASE) >> 2);
        off = addr[1:0];
        case (ls)
            ls_lb: ref_mem[idx][8 * off +: 8] = data[7:0];
            ls_lh: begin
                if (off[1]) begin
                    ref_mem[idx][31:16] = data[15:0];
                end else begin
                    ref_mem[idx][15:0] = data[15:0];
                end
            end
            ls_ld: begin
                ref_mem[idx]     = data[31:0];
                ref_mem[idx + 1] = data[63:32];
            end
            default: ref_mem[idx] = data[31:0];
        endcase
    endfunction

    // called 1 ns after an edge, done already low
    task automatic wait_done(input logic is_read);
        int cycles;
        cycles = 0;
        while ((is_read ? bus_read_done : bus_write_done) == 1'b0 && cycles < 8) begin
            @(posedge CLOCK_50);
            #1;
            cycles++;
        end
        if (cycles >= 8) begin
            other_errors++;
            $display("bus access at %0t never completed", $time);
        end
        // spare edge so the read check still sees this expected value
        @(posedge CLOCK_50);
        #1;
    endtask

    task automatic read_access(input addr_t addr, input ls_type_t ls, input dword_t expect_val);
        exp_rdata     = expect_val;
        bus_req.addr  = addr;
        bus_req.ls    = ls;
        bus_req.rd_en = 1'b1;
        @(posedge CLOCK_50);
        #1;
        bus_req.rd_en = 1'b0;
        wait_done(1'b1);
    endtask

    task automatic write_access(input addr_t addr, input ls_type_t ls, input dword_t data);
        bus_req.addr  = addr;
        bus_req.ls    = ls;
        bus_req.wdata = data;
        bus_req.wr_en = 1'b1;
        @(posedge CLOCK_50);
        #1;
        bus_req.wr_en = 1'b0;
        wait_done(1'b0);
    endtask

    task automatic ram_store(input addr_t addr, input ls_type_t ls, input dword_t data);
        store_ref(addr, ls, data);
        write_access(addr, ls, data);
    endtask

    task automatic ram_load(input addr_t addr, input ls_type_t ls);
        read_access(addr, ls, load_ref(addr, ls));
    endtask

    // one byte, high for a cycle then low for a cycle
    task automatic send_sd_byte(input byte_t value);
        sd_stream.dout           = value;
        sd_stream.byte_available = 1'b1;
        @(posedge CLOCK_50);
        #1;
        sd_stream.byte_available = 1'b0;
        @(posedge CLOCK_50);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge CLOCK_50);
        end
        #1;
    endtask

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) begin
            @(posedge CLOCK_50);
        end
        $display("watchdog expired before the tests finished");
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors + 1);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int    idx;
        int    pos;
        addr_t base;
        byte_t ascii;

        CLOCK_50      = 1'b0;
        KEY0          = 1'b0;
        bus_req       = '0;
        key           = '0;
        interrupt_ack = 1'b0;
        sd_ready      = 1'b0;
        sd_stream     = '0;
        exp_rdata     = '0;
        exp_uart      = '0;
        exp_sector    = '0;
        value_errors  = 0;
        other_errors  = 0;
        rd_wait       = 0;
        wr_wait       = 0;
        uart_pulses   = 0;
        start_pulses  = 0;
        void'($urandom(32'ha18b));

        // reset for 2 cycles
        repeat (2) begin
            @(posedge CLOCK_50);
        end
        #1;
        KEY0 = 1'b1;
        idle_cycles(1);

        // word, half and byte stores, then every load width
        for (int i = 0; i < N_WORDS; i++) begin
            idx  = $urandom_range(`RAM_WORDS - 1);
            base = `RAM_BASE + addr_t'(idx) * 4;
            ram_store(base, ls_lw, {$urandom, $urandom});
            ram_store(base + 2 * $urandom_range(1), ls_lh, {$urandom, $urandom});
            ram_store(base + $urandom_range(3), ls_lb, {$urandom, $urandom});
            ram_load(base, ls_lw);
            ram_load(base + 2 * $urandom_range(1), ls_lh);
            ram_load(base + 2 * $urandom_range(1), ls_lhu);
            ram_load(base + $urandom_range(3), ls_lb);
            ram_load(base + $urandom_range(3), ls_lbu);
        end

        // doubles with a known word on each side
        for (int i = 0; i < N_DOUBLES; i++) begin
            idx  = 2 * $urandom_range(1, `RAM_WORDS / 2 - 2);
            base = `RAM_BASE + addr_t'(idx) * 4;
            ram_store(base - 4, ls_lw, {32'd0, $urandom});
            ram_store(base + 8, ls_lw, {32'd0, $urandom});
            ram_store(base, ls_ld, {$urandom, $urandom});
            ram_load(base, ls_ld);
            ram_load(base - 4, ls_lw);
            ram_load(base + 8, ls_lw);
        end

        // key press, ascii read back, ack
        ascii       = byte_t'($urandom_range(1, 255));
        key.ascii   = ascii;
        key.pressed = 1'b1;
        idle_cycles(1);
        key.pressed = 1'b0;
        idle_cycles(1);
        read_access(`KEY_ADDR, ls_lbu, {56'd0, ascii});
        interrupt_ack = 1'b1;
        idle_cycles(1);
        interrupt_ack = 1'b0;
        idle_cycles(1);
        // null character must not interrupt
        key.ascii   = 8'd0;
        key.pressed = 1'b1;
        idle_cycles(1);
        key.pressed = 1'b0;
        idle_cycles(2);

        // console and sd control writes
        exp_uart = $urandom;
        write_access(`UART_ADDR, ls_lw, {$urandom, exp_uart});
        exp_sector = $urandom;
        write_access(`SDC_SECTOR_ADDR, ls_lw, {$urandom, exp_sector});
        write_access(`SDC_READ_ADDR, ls_lw, 64'd0);

        // ready flag follows the pin
        sd_ready = 1'b1;
        read_access(`SDC_READY_ADDR, ls_lw, 64'd1);
        sd_ready = 1'b0;
        read_access(`SDC_READY_ADDR, ls_lw, 64'd0);

        // sector stream with a flag read halfway
        for (int i = 0; i < STREAM_LEN; i++) begin
            sector_ref[i] = byte_t'($urandom);
            send_sd_byte(sector_ref[i]);
            if (i == STREAM_LEN / 2) begin
                read_access(`SDC_AVAIL_ADDR, ls_lw, 64'd0);
            end
        end
        idle_cycles(2);
        read_access(`SDC_AVAIL_ADDR, ls_lw, 64'd1);

        // both ends of the buffer, then random slots
        read_access(`SDC_BUF_BASE, ls_lbu, {56'd0, sector_ref[0]});
        read_access(`SDC_BUF_BASE + `SECTOR_BYTES - 1, ls_lbu,
                    {56'd0, sector_ref[`SECTOR_BYTES - 1]});
        for (int i = 0; i < N_BUF_READS - 2; i++) begin
            pos = $urandom_range(`SECTOR_BYTES - 1);
            read_access(`SDC_BUF_BASE + addr_t'(pos), ls_lbu, {56'd0, sector_ref[pos]});
        end

        idle_cycles(3);
        assert (uart_pulses == 1)
        else begin
            other_errors++;
            $display("uart_write pulsed %0d times for one console write", uart_pulses);
        end
        assert (start_pulses == 1)
        else begin
            other_errors++;
            $display("sd_rd_start pulsed %0d times for one read start", start_pulses);
        end

        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+.
bus_pkg.sv
periph_pkg.sv
ram_bank.sv
sector_fill_counter.sv
sector_buffer.sv
key_irq_ctrl.sv
bus_access_fsm.sv
soc_bus_top.sv
tb_soc_bus.sv
